// ==== source/boot_params.svh ====
//////////////////////////////
// Boot loader constants
// Host offsets are word aligned and lie below the host mask
// Credit limit also sets the router tag queue depth
//////////////////////////////
`ifndef BOOT_PARAMS_SVH
`define BOOT_PARAMS_SVH

`define BOOT_ADDR_W          32
`define BOOT_DATA_W          32
`define BOOT_HOST_BASE       32'h0010_0000
`define BOOT_HOST_MASK       32'hfff0_0000
`define BOOT_REG_CORE_ID     32'h0000_0000
`define BOOT_REG_IMAGE_BASE  32'h0000_0004
`define BOOT_REG_FREEZE      32'h0000_0008
`define BOOT_REG_FINISH      32'h0000_000c
`define BOOT_CFG_CORE_ID     3
`define BOOT_CFG_IMAGE_BASE  32'h8000_0000
`define BOOT_CFG_ENTRIES     3
`define BOOT_IMAGE_WORDS     16
`define BOOT_IMAGE_PATTERN   32'ha5a5_0000
`define BOOT_IMAGE_STEP      32'h0001_0101
`define BOOT_MAX_CREDITS     4

`endif

// ==== source/boot_pkg.sv ====
//////////////////////////////
// Shared boot channel types
// Commands carry one data word, no byte masks
//////////////////////////////
`include "boot_params.svh"

package boot_pkg;

   typedef enum logic
   {
      MEM_WRITE = 1'b0,
      MEM_READ  = 1'b1
   } mem_op_e;

   typedef enum logic [1:0]
   {
      IDLE,
      ISSUE,
      DRAIN,
      DONE
   } loader_state_e;

   typedef enum logic
   {
      DEST_HOST = 1'b0,
      DEST_MEM  = 1'b1
   } dest_e;

   typedef struct packed
   {
      mem_op_e                 op;
      logic [`BOOT_ADDR_W-1:0] addr;
      logic [`BOOT_DATA_W-1:0] data;
   } mem_cmd_s;

   typedef struct packed
   {
      mem_op_e                 op;
      logic [`BOOT_DATA_W-1:0] data;
   } mem_resp_s;

   typedef struct packed
   {
      logic                    freeze;
      logic [7:0]              core_id;
      logic [`BOOT_ADDR_W-1:0] image_base;
   } boot_cfg_s;

endpackage

// ==== source/cfg_loader.sv ====
//////////////////////////////
// Configuration writer
// Table is fixed at build time, writes only
//////////////////////////////
`timescale 1ns/1ps
`include "boot_params.svh"

module cfg_loader
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   output boot_pkg::mem_cmd_s  cmd_o,
   output logic                cmd_v_o,
   input  logic                cmd_ready_i,
   input  boot_pkg::mem_resp_s resp_i,
   input  logic                resp_v_i,
   output logic                resp_ready_o,
   output logic                done_o
);

   localparam int CNT_W = $clog2(`BOOT_CFG_ENTRIES + 1);

   boot_pkg::loader_state_e state_q, state_d;
   logic [CNT_W-1:0]        idx_q, ack_q;
   logic                    issue, ack, last_issue, last_ack;

   assign issue      = cmd_v_o && cmd_ready_i;
   assign ack        = resp_v_i && resp_ready_o && (resp_i.op == boot_pkg::MEM_WRITE);
   assign last_issue = issue && (idx_q == CNT_W'(`BOOT_CFG_ENTRIES - 1));
   assign last_ack   = ack && (ack_q == CNT_W'(`BOOT_CFG_ENTRIES - 1));

   assign cmd_v_o      = (state_q == boot_pkg::ISSUE);
   assign resp_ready_o = 1'b1;
   assign done_o       = (state_q == boot_pkg::DONE);

   // Entry order is core id, image base, freeze set
   always_comb
   begin
      cmd_o.op = boot_pkg::MEM_WRITE;
      case (idx_q)
         CNT_W'(0):
         begin
            cmd_o.addr = `BOOT_HOST_BASE | `BOOT_REG_CORE_ID;
            cmd_o.data = `BOOT_DATA_W'(`BOOT_CFG_CORE_ID);
         end
         CNT_W'(1):
         begin
            cmd_o.addr = `BOOT_HOST_BASE | `BOOT_REG_IMAGE_BASE;
            cmd_o.data = `BOOT_CFG_IMAGE_BASE;
         end
         default:
         begin
            cmd_o.addr = `BOOT_HOST_BASE | `BOOT_REG_FREEZE;
            cmd_o.data = `BOOT_DATA_W'(1);
         end
      endcase
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         boot_pkg::IDLE:  state_d = boot_pkg::ISSUE;
         boot_pkg::ISSUE: if (last_issue) state_d = boot_pkg::DRAIN;
         boot_pkg::DRAIN: if (last_ack) state_d = boot_pkg::DONE;
         default:         state_d = boot_pkg::DONE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= boot_pkg::IDLE;
         idx_q   <= '0;
         ack_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (issue)
            idx_q <= idx_q + 1'b1;
         if (ack)
            ack_q <= ack_q + 1'b1;
      end
   end

endmodule

// ==== source/image_loader.sv ====
//////////////////////////////
// Image writer
// Runs once per reset, image base sampled from cfg
// Closes with freeze clear, then finish
//////////////////////////////
`timescale 1ns/1ps
`include "boot_params.svh"

module image_loader
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                start_i,
   input  boot_pkg::boot_cfg_s cfg_i,
   output boot_pkg::mem_cmd_s  cmd_o,
   output logic                cmd_v_o,
   input  logic                cmd_ready_i,
   input  boot_pkg::mem_resp_s resp_i,
   input  logic                resp_v_i,
   output logic                resp_ready_o,
   output logic                done_o
);

   localparam int TOTAL = `BOOT_IMAGE_WORDS + 2;
   localparam int CNT_W = $clog2(TOTAL + 1);

   boot_pkg::loader_state_e state_q, state_d;
   logic [CNT_W-1:0]        idx_q, ack_q;
   logic                    issue, ack;

   assign issue        = cmd_v_o && cmd_ready_i;
   assign ack          = resp_v_i && resp_ready_o && (resp_i.op == boot_pkg::MEM_WRITE);
   assign cmd_v_o      = (state_q == boot_pkg::ISSUE);
   assign resp_ready_o = 1'b1;
   assign done_o       = (state_q == boot_pkg::DONE);

   always_comb
   begin
      cmd_o.op = boot_pkg::MEM_WRITE;
      if (idx_q < CNT_W'(`BOOT_IMAGE_WORDS))
      begin
         cmd_o.addr = cfg_i.image_base + (`BOOT_ADDR_W'(idx_q) << 2);
         cmd_o.data = `BOOT_IMAGE_PATTERN + `BOOT_DATA_W'(idx_q) * `BOOT_IMAGE_STEP;
      end
      else if (idx_q == CNT_W'(`BOOT_IMAGE_WORDS))
      begin
         cmd_o.addr = `BOOT_HOST_BASE | `BOOT_REG_FREEZE;
         cmd_o.data = '0;
      end
      else
      begin
         cmd_o.addr = `BOOT_HOST_BASE | `BOOT_REG_FINISH;
         cmd_o.data = `BOOT_DATA_W'(1);
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         boot_pkg::IDLE:  if (start_i) state_d = boot_pkg::ISSUE;
         boot_pkg::ISSUE: if (issue && idx_q == CNT_W'(TOTAL - 1)) state_d = boot_pkg::DRAIN;
         boot_pkg::DRAIN: if (ack && ack_q == CNT_W'(TOTAL - 1)) state_d = boot_pkg::DONE;
         default:         state_d = boot_pkg::DONE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= boot_pkg::IDLE;
         idx_q   <= '0;
         ack_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (issue)
            idx_q <= idx_q + 1'b1;
         if (ack)
            ack_q <= ack_q + 1'b1;
      end
   end

   // Configuration must stay complete for the whole image load
   a_no_cmd_before_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cmd_v_o |-> start_i);

endmodule

// ==== source/load_arbiter.sv ====
//////////////////////////////
// Loader channel arbiter
// Config side owns the channel until cfg_done
// Owner switch assumes no config response in flight
//////////////////////////////
`timescale 1ns/1ps
`include "boot_params.svh"

module load_arbiter
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                cfg_done_i,
   input  boot_pkg::mem_cmd_s  cfg_cmd_i,
   input  logic                cfg_cmd_v_i,
   output logic                cfg_cmd_ready_o,
   output boot_pkg::mem_resp_s cfg_resp_o,
   output logic                cfg_resp_v_o,
   input  logic                cfg_resp_ready_i,
   input  boot_pkg::mem_cmd_s  img_cmd_i,
   input  logic                img_cmd_v_i,
   output logic                img_cmd_ready_o,
   output boot_pkg::mem_resp_s img_resp_o,
   output logic                img_resp_v_o,
   input  logic                img_resp_ready_i,
   output boot_pkg::mem_cmd_s  cmd_o,
   output logic                cmd_v_o,
   input  logic                cmd_ready_i,
   input  boot_pkg::mem_resp_s resp_i,
   input  logic                resp_v_i,
   output logic                resp_ready_o
);

   localparam int CRD_W = $clog2(`BOOT_MAX_CREDITS + 1);

   logic [CRD_W-1:0] credits_q;
   logic             credit_ok, cmd_fire, resp_fire;

   // Credits only grow on a transfer, so a pending valid is never pulled
   assign credit_ok = (credits_q != CRD_W'(`BOOT_MAX_CREDITS));
   assign cmd_fire  = cmd_v_o && cmd_ready_i;
   assign resp_fire = resp_v_i && resp_ready_o;

   assign cmd_o           = cfg_done_i ? img_cmd_i : cfg_cmd_i;
   assign cmd_v_o         = credit_ok && (cfg_done_i ? img_cmd_v_i : cfg_cmd_v_i);
   assign cfg_cmd_ready_o = !cfg_done_i && credit_ok && cmd_ready_i;
   assign img_cmd_ready_o = cfg_done_i && credit_ok && cmd_ready_i;

   assign cfg_resp_o   = resp_i;
   assign img_resp_o   = resp_i;
   assign cfg_resp_v_o = !cfg_done_i && resp_v_i;
   assign img_resp_v_o = cfg_done_i && resp_v_i;
   assign resp_ready_o = cfg_done_i ? img_resp_ready_i : cfg_resp_ready_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         credits_q <= '0;
      else if (cmd_fire && !resp_fire)
         credits_q <= credits_q + 1'b1;
      else if (resp_fire && !cmd_fire)
         credits_q <= credits_q - 1'b1;
   end

   a_credit_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      credits_q <= CRD_W'(`BOOT_MAX_CREDITS));

endmodule

// ==== source/host_router.sv ====
//////////////////////////////
// Host and memory router
// Responses leave in command order
// Upstream must limit commands in flight to the credit count
//////////////////////////////
`timescale 1ns/1ps
`include "boot_params.svh"

module host_router
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  boot_pkg::mem_cmd_s  cmd_i,
   input  logic                cmd_v_i,
   output logic                cmd_ready_o,
   output boot_pkg::mem_resp_s resp_o,
   output logic                resp_v_o,
   input  logic                resp_ready_i,
   output boot_pkg::mem_cmd_s  host_cmd_o,
   output logic                host_cmd_v_o,
   input  logic                host_cmd_ready_i,
   input  boot_pkg::mem_resp_s host_resp_i,
   input  logic                host_resp_v_i,
   output logic                host_resp_ready_o,
   output boot_pkg::mem_cmd_s  mem_cmd_o,
   output logic                mem_cmd_v_o,
   input  logic                mem_cmd_ready_i,
   input  boot_pkg::mem_resp_s mem_resp_i,
   input  logic                mem_resp_v_i,
   output logic                mem_resp_ready_o
);

   localparam int DEPTH = `BOOT_MAX_CREDITS;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   boot_pkg::dest_e  tag_q [DEPTH];
   boot_pkg::dest_e  cmd_dest, head;
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             full, empty, push, pop;

   assign full  = (cnt_q == CNT_W'(DEPTH));
   assign empty = (cnt_q == '0);
   assign head  = tag_q[rd_ptr_q];

   // Address decode
   assign cmd_dest = ((cmd_i.addr & `BOOT_HOST_MASK) == `BOOT_HOST_BASE) ?
                     boot_pkg::DEST_HOST : boot_pkg::DEST_MEM;

   assign host_cmd_o   = cmd_i;
   assign mem_cmd_o    = cmd_i;
   assign host_cmd_v_o = cmd_v_i && !full && (cmd_dest == boot_pkg::DEST_HOST);
   assign mem_cmd_v_o  = cmd_v_i && !full && (cmd_dest == boot_pkg::DEST_MEM);
   assign cmd_ready_o  = !full &&
                         ((cmd_dest == boot_pkg::DEST_HOST) ? host_cmd_ready_i : mem_cmd_ready_i);

   // Only the head destination may answer
   assign resp_o            = (head == boot_pkg::DEST_HOST) ? host_resp_i : mem_resp_i;
   assign resp_v_o          = !empty &&
                              ((head == boot_pkg::DEST_HOST) ? host_resp_v_i : mem_resp_v_i);
   assign host_resp_ready_o = !empty && (head == boot_pkg::DEST_HOST) && resp_ready_i;
   assign mem_resp_ready_o  = !empty && (head == boot_pkg::DEST_MEM) && resp_ready_i;

   assign push = cmd_v_i && cmd_ready_o;
   assign pop  = resp_v_o && resp_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (push)
         tag_q[wr_ptr_q] <= cmd_dest;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (push && !pop)
            cnt_q <= cnt_q + 1'b1;
         else if (pop && !push)
            cnt_q <= cnt_q - 1'b1;
      end
   end

   // Arbiter credits keep a free tag slot for every offered command
   a_tag_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cmd_v_i |-> !full);

endmodule

// ==== source/host_regs.sv ====
//////////////////////////////
// Host register block
// One access at a time, ack one cycle later
// Unknown offsets are acked and ignored
//////////////////////////////
`timescale 1ns/1ps
`include "boot_params.svh"

module host_regs
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  boot_pkg::mem_cmd_s  cmd_i,
   input  logic                cmd_v_i,
   output logic                cmd_ready_o,
   output boot_pkg::mem_resp_s resp_o,
   output logic                resp_v_o,
   input  logic                resp_ready_i,
   output boot_pkg::boot_cfg_s cfg_o,
   output logic                finish_o
);

   boot_pkg::boot_cfg_s     cfg_q;
   boot_pkg::mem_resp_s     resp_q;
   logic                    finish_q, pending_q, accept, wr;
   logic [`BOOT_ADDR_W-1:0] offset;
   logic [`BOOT_DATA_W-1:0] rd_data;

   assign offset      = cmd_i.addr & ~`BOOT_HOST_MASK;
   assign cmd_ready_o = !pending_q;
   assign accept      = cmd_v_i && cmd_ready_o;
   assign wr          = accept && (cmd_i.op == boot_pkg::MEM_WRITE);

   always_comb
   begin
      case (offset)
         `BOOT_REG_CORE_ID:    rd_data = `BOOT_DATA_W'(cfg_q.core_id);
         `BOOT_REG_IMAGE_BASE: rd_data = cfg_q.image_base;
         `BOOT_REG_FREEZE:     rd_data = `BOOT_DATA_W'(cfg_q.freeze);
         `BOOT_REG_FINISH:     rd_data = `BOOT_DATA_W'(finish_q);
         default:              rd_data = '0;
      endcase
   end

   // Response payload, held until taken
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         resp_q.op   <= cmd_i.op;
         resp_q.data <= (cmd_i.op == boot_pkg::MEM_READ) ? rd_data : cmd_i.data;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         pending_q        <= 1'b0;
         cfg_q.freeze     <= 1'b1;
         cfg_q.core_id    <= '0;
         cfg_q.image_base <= '0;
         finish_q         <= 1'b0;
      end
      else
      begin
         if (accept)
            pending_q <= 1'b1;
         else if (resp_ready_i)
            pending_q <= 1'b0;
         if (wr && offset == `BOOT_REG_CORE_ID)
            cfg_q.core_id <= cmd_i.data[7:0];
         if (wr && offset == `BOOT_REG_IMAGE_BASE)
            cfg_q.image_base <= cmd_i.data;
         if (wr && offset == `BOOT_REG_FREEZE)
            cfg_q.freeze <= cmd_i.data[0];
         if (wr && offset == `BOOT_REG_FINISH)
            finish_q <= cmd_i.data[0];
      end
   end

   assign resp_o   = resp_q;
   assign resp_v_o = pending_q;
   assign cfg_o    = cfg_q;
   assign finish_o = finish_q;

endmodule

// ==== source/boot_ctrl_top.sv ====
//////////////////////////////
// Boot controller top
// Memory port sees image writes only
//////////////////////////////
`timescale 1ns/1ps

module boot_ctrl_top
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   output boot_pkg::mem_cmd_s  mem_cmd_o,
   output logic                mem_cmd_v_o,
   input  logic                mem_cmd_ready_i,
   input  boot_pkg::mem_resp_s mem_resp_i,
   input  logic                mem_resp_v_i,
   output logic                mem_resp_ready_o,
   output boot_pkg::boot_cfg_s cfg_o,
   output logic                freeze_o,
   output logic                finish_o,
   output logic                done_o
);

   boot_pkg::mem_cmd_s  cfg_cmd, img_cmd, load_cmd, host_cmd;
   boot_pkg::mem_resp_s cfg_resp, img_resp, load_resp, host_resp;
   logic                cfg_cmd_v, cfg_cmd_ready, cfg_resp_v, cfg_resp_ready;
   logic                img_cmd_v, img_cmd_ready, img_resp_v, img_resp_ready;
   logic                load_cmd_v, load_cmd_ready, load_resp_v, load_resp_ready;
   logic                host_cmd_v, host_cmd_ready, host_resp_v, host_resp_ready;
   logic                cfg_done;

   cfg_loader cfg_loader0
   (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .cmd_o(cfg_cmd), .cmd_v_o(cfg_cmd_v), .cmd_ready_i(cfg_cmd_ready),
      .resp_i(cfg_resp), .resp_v_i(cfg_resp_v), .resp_ready_o(cfg_resp_ready),
      .done_o(cfg_done)
   );

   image_loader image_loader0
   (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(cfg_done), .cfg_i(cfg_o),
      .cmd_o(img_cmd), .cmd_v_o(img_cmd_v), .cmd_ready_i(img_cmd_ready),
      .resp_i(img_resp), .resp_v_i(img_resp_v), .resp_ready_o(img_resp_ready),
      .done_o(done_o)
   );

   load_arbiter load_arbiter0
   (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .cfg_done_i(cfg_done),
      .cfg_cmd_i(cfg_cmd), .cfg_cmd_v_i(cfg_cmd_v), .cfg_cmd_ready_o(cfg_cmd_ready),
      .cfg_resp_o(cfg_resp), .cfg_resp_v_o(cfg_resp_v), .cfg_resp_ready_i(cfg_resp_ready),
      .img_cmd_i(img_cmd), .img_cmd_v_i(img_cmd_v), .img_cmd_ready_o(img_cmd_ready),
      .img_resp_o(img_resp), .img_resp_v_o(img_resp_v), .img_resp_ready_i(img_resp_ready),
      .cmd_o(load_cmd), .cmd_v_o(load_cmd_v), .cmd_ready_i(load_cmd_ready),
      .resp_i(load_resp), .resp_v_i(load_resp_v), .resp_ready_o(load_resp_ready)
   );

   host_router host_router0
   (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .cmd_i(load_cmd), .cmd_v_i(load_cmd_v), .cmd_ready_o(load_cmd_ready),
      .resp_o(load_resp), .resp_v_o(load_resp_v), .resp_ready_i(load_resp_ready),
      .host_cmd_o(host_cmd), .host_cmd_v_o(host_cmd_v), .host_cmd_ready_i(host_cmd_ready),
      .host_resp_i(host_resp), .host_resp_v_i(host_resp_v),
      .host_resp_ready_o(host_resp_ready),
      .mem_cmd_o(mem_cmd_o), .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_ready_i(mem_cmd_ready_i),
      .mem_resp_i(mem_resp_i), .mem_resp_v_i(mem_resp_v_i), .mem_resp_ready_o(mem_resp_ready_o)
   );

   host_regs host_regs0
   (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .cmd_i(host_cmd), .cmd_v_i(host_cmd_v), .cmd_ready_o(host_cmd_ready),
      .resp_o(host_resp), .resp_v_o(host_resp_v), .resp_ready_i(host_resp_ready),
      .cfg_o(cfg_o), .finish_o(finish_o)
   );

   assign freeze_o = cfg_o.freeze;

endmodule

// ==== testbench/tb_boot_ctrl.sv ====
//////////////////////////////
// Boot controller testbench
// Memory model answers in order after 0 to 5 extra cycles
// Host-region writes are never expected on the memory port
//////////////////////////////
`timescale 1ns/1ps
`include "boot_params.svh"

module tb_boot_ctrl;

   localparam int LOAD_CYCLES    = 40 * `BOOT_IMAGE_WORDS + 100;
   // Two full loads and the partial one
   localparam int TIMEOUT_CYCLES = 3 * LOAD_CYCLES;
   localparam int MAX_UNANSWERED = 4;

   logic                clk_i;
   logic                arst_n_i;
   boot_pkg::mem_cmd_s  mem_cmd_o;
   logic                mem_cmd_v_o;
   logic                mem_cmd_ready_i;
   boot_pkg::mem_resp_s mem_resp_i;
   logic                mem_resp_v_i;
   logic                mem_resp_ready_o;
   boot_pkg::boot_cfg_s cfg_o;
   logic                freeze_o;
   logic                finish_o;
   logic                done_o;

   integer              seed = 32'hc0a4;
   int                  cyc = 0;
   int                  wd_cycles = 0;
   int                  check_cnt = 0;
   int                  mismatch_cnt = 0;
   int                  fail_cnt = 0;
   logic [31:0]         rnd_ready;
   boot_pkg::mem_cmd_s  wr_log[$];
   logic [31:0]         pend_data[$];
   int                  pend_due[$];

   boot_ctrl_top dut0
   (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .mem_cmd_o(mem_cmd_o), .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_ready_i(mem_cmd_ready_i),
      .mem_resp_i(mem_resp_i), .mem_resp_v_i(mem_resp_v_i),
      .mem_resp_ready_o(mem_resp_ready_o),
      .cfg_o(cfg_o), .freeze_o(freeze_o), .finish_o(finish_o), .done_o(done_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic note_failure(input string msg);
      fail_cnt++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic compare_cmd(input string name, input boot_pkg::mem_cmd_s act,
                              input boot_pkg::mem_cmd_s exp);
      check_cnt++;
      if (act !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   task automatic compare_cfg(input string name, input boot_pkg::boot_cfg_s act,
                              input boot_pkg::boot_cfg_s exp);
      check_cnt++;
      if (act !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   task automatic compare_bit(input string name, input logic act, input logic exp);
      check_cnt++;
      if (act !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, act, exp);
      end
   endtask

   task automatic compare_count(input string name, input int act, input int exp);
      check_cnt++;
      if (act != exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, act, exp);
      end
   endtask

   // Memory side: transfers are taken at the rising edge
   always @(posedge clk_i)
   begin
      cyc++;
      if (!arst_n_i)
      begin
         pend_data.delete();
         pend_due.delete();
      end
      else
      begin
         if (mem_resp_ready_o && pend_due.size() == 0)
            note_failure("mem_resp_ready_o was high with no memory write unanswered");
         if (mem_cmd_v_o && mem_cmd_ready_i)
         begin
            if ((mem_cmd_o.addr & `BOOT_HOST_MASK) == `BOOT_HOST_BASE)
               note_failure("host-region address reached the memory port");
            if (mem_cmd_o.op != boot_pkg::MEM_WRITE)
               note_failure("memory port received a command that is not a write");
            wr_log.push_back(mem_cmd_o);
            pend_data.push_back(mem_cmd_o.data);
            pend_due.push_back(cyc + ($unsigned($random(seed)) % 6));
            if (pend_due.size() > MAX_UNANSWERED)
               note_failure("more than 4 memory writes were unanswered");
         end
         if (mem_resp_v_i && mem_resp_ready_o)
         begin
            void'(pend_data.pop_front());
            void'(pend_due.pop_front());
         end
      end
   end

   // Head response stays offered until taken
   always @(negedge clk_i)
   begin
      rnd_ready       = $random(seed);
      mem_cmd_ready_i = (rnd_ready[1:0] != 2'b00);
      if (pend_due.size() > 0 && pend_due[0] <= cyc)
      begin
         mem_resp_v_i    = 1'b1;
         mem_resp_i.op   = boot_pkg::MEM_WRITE;
         mem_resp_i.data = pend_data[0];
      end
      else
      begin
         mem_resp_v_i = 1'b0;
         mem_resp_i   = '0;
      end
   end

   always @(posedge clk_i)
   begin
      wd_cycles++;
      if (wd_cycles > TIMEOUT_CYCLES)
      begin
         $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic apply_reset();
      @(negedge clk_i);
      arst_n_i = 1'b0;
      wr_log.delete();
      repeat (2) @(negedge clk_i);
      arst_n_i = 1'b1;
   endtask

   task automatic test_reset_values();
      compare_bit("mem_cmd_v_o after reset", mem_cmd_v_o, 1'b0);
      compare_bit("done_o after reset", done_o, 1'b0);
      compare_bit("finish_o after reset", finish_o, 1'b0);
      compare_bit("freeze_o after reset", freeze_o, 1'b1);
   endtask

   task automatic test_first_cfg();
      boot_pkg::boot_cfg_s exp;
      int                  n;
      exp.freeze     = 1'b1;
      exp.core_id    = 8'd3;
      exp.image_base = 32'h8000_0000;
      n = 0;
      while (!mem_cmd_v_o && n < LOAD_CYCLES)
      begin
         @(negedge clk_i);
         n++;
      end
      if (mem_cmd_v_o)
         compare_cfg("cfg_o at first memory command", cfg_o, exp);
      else
         note_failure("no memory command appeared after configuration");
   endtask

   task automatic test_image_load();
      boot_pkg::mem_cmd_s  exp_cmd;
      boot_pkg::boot_cfg_s exp_cfg;
      int                  n;
      int                  i;
      n = 0;
      while (!done_o && n < LOAD_CYCLES)
      begin
         @(negedge clk_i);
         n++;
      end
      if (!done_o)
         note_failure("done_o did not rise after the image load");
      // Late or repeated writes would show up here
      repeat (10) @(negedge clk_i);
      compare_count("memory write count", wr_log.size(), `BOOT_IMAGE_WORDS);
      for (i = 0; i < wr_log.size() && i < `BOOT_IMAGE_WORDS; i++)
      begin
         exp_cmd.op   = boot_pkg::MEM_WRITE;
         exp_cmd.addr = 32'h8000_0000 + 32'(4 * i);
         exp_cmd.data = `BOOT_IMAGE_PATTERN + 32'(i) * `BOOT_IMAGE_STEP;
         compare_cmd($sformatf("memory write %0d", i), wr_log[i], exp_cmd);
      end
      compare_count("unanswered memory writes", pend_due.size(), 0);
      exp_cfg.freeze     = 1'b0;
      exp_cfg.core_id    = 8'd3;
      exp_cfg.image_base = 32'h8000_0000;
      compare_cfg("cfg_o after load", cfg_o, exp_cfg);
      compare_bit("freeze_o after load", freeze_o, 1'b0);
      compare_bit("finish_o after load", finish_o, 1'b1);
      compare_bit("done_o after load", done_o, 1'b1);
   endtask

   task automatic test_mid_load_reset();
      int n;
      apply_reset();
      test_reset_values();
      n = 0;
      while (wr_log.size() < `BOOT_IMAGE_WORDS / 2 && n < LOAD_CYCLES)
      begin
         @(negedge clk_i);
         n++;
      end
      if (wr_log.size() < `BOOT_IMAGE_WORDS / 2)
         note_failure("image load stalled before the mid-load reset");
      apply_reset();
      test_reset_values();
      test_first_cfg();
      test_image_load();
   endtask

   initial
   begin
      arst_n_i        = 1'b0;
      mem_cmd_ready_i = 1'b0;
      mem_resp_v_i    = 1'b0;
      mem_resp_i      = '0;
      apply_reset();
      test_reset_values();
      test_first_cfg();
      test_image_load();
      test_mid_load_reset();
      $display("Checks: %0d, mismatches: %0d, other failures: %0d",
               check_cnt, mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== boot_ctrl_top.f ====
+incdir+source
source/boot_pkg.sv
source/cfg_loader.sv
source/image_loader.sv
source/load_arbiter.sv
source/host_router.sv
source/host_regs.sv
source/boot_ctrl_top.sv
testbench/tb_boot_ctrl.sv
